/* build.f */
cache_pkg.sv
row_if.sv
row_ram.sv
cache_ctrl.sv
wb_cache.sv
cache_checker.sv
tb_wb_cache.sv

/* cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_checker #(
  parameter logic [31:0] FILL_XOR = 32'h0
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         s_cyc_i,
  input  wire logic                         s_stb_i,
  input  wire logic                         s_we_i,
  input  wire logic [cache_pkg::ADDR_W-1:0] s_adr_i,
  input  wire logic [cache_pkg::SEL_W-1:0]  s_sel_i,
  input  wire logic [cache_pkg::DATA_W-1:0] s_dat_i,
  input  wire logic [cache_pkg::DATA_W-1:0] s_dat_o,
  input  wire logic                         s_ack_o,
  input  wire logic                         m_cyc_o,
  input  wire logic                         m_stb_o,
  input  wire logic                         m_we_o,
  input  wire logic [cache_pkg::ADDR_W-1:0] m_adr_o,
  input  wire logic [cache_pkg::SEL_W-1:0]  m_sel_o,
  input  wire logic [cache_pkg::DATA_W-1:0] m_dat_o,
  input  wire logic                         m_ack_i,
  input  wire logic                         exp_hit_i,
  output int                                err_cnt_o
);
  import cache_pkg::*;

  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  logic [ROWS-1:0]   valid_m;
  logic [TAG_W-1:0]  tag_m [ROWS];
  logic [3:0]        dirty_m [ROWS];
  logic [57:0]       expect_q [$]; // {we, address, data} of each master transfer.
  logic [57:0]       bus_now;
  logic [57:0]       prev_xfer;
  addr_t             req;
  logic              req_seen = 1'b0;
  logic              prev_pend = 1'b0;
  logic              prev_ack = 1'b0;
  int                lat;
  int                xfers;
  int                cycles;

  initial err_cnt_o = 0;

  function automatic logic [DATA_W-1:0] shadow_word(input logic [ADDR_W-1:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return DATA_W'(a) ^ FILL_XOR; // untouched memory holds its fill pattern.
  endfunction

  task automatic value_error(input string name, input logic [57:0] got, input logic [57:0] exp);
    $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    err_cnt_o++;
  endtask

  task automatic fault(input string msg);
    $display("%s at %0t", msg, $time);
    err_cnt_o++;
  endtask

  task automatic start_request();
    logic [ADDR_W-1:0] victim;
    req = addr_t'(s_adr_i);
    req_seen = 1'b1;
    lat = 0;
    xfers = 0;
    if (!(valid_m[req.row] && tag_m[req.row] == req.tag)) begin
      for (int w = 0; w < WORDS_PER_ROW; w++) begin
        victim = {tag_m[req.row], req.row, WSEL_W'(w)};
        if (valid_m[req.row] && dirty_m[req.row][w]) begin
          expect_q.push_back({1'b1, victim, shadow_word(victim)});
        end
      end
      for (int w = 0; w < WORDS_PER_ROW; w++) begin
        expect_q.push_back({1'b0, req.tag, req.row, WSEL_W'(w), 32'h0});
      end
      valid_m[req.row] = 1'b1;
      tag_m[req.row] = req.tag;
      dirty_m[req.row] = '0;
    end
  endtask

  task automatic master_xfer();
    logic [57:0] got;
    logic [57:0] exp;
    got = {m_we_o, m_adr_o, m_we_o ? m_dat_o : 32'h0};
    xfers++;
    if (expect_q.size() == 0) begin
      fault("unexpected transfer on the master bus");
    end else begin
      exp = expect_q.pop_front();
      if (got !== exp) value_error("m_we_o/m_adr_o/m_dat_o", got, exp);
    end
  endtask

  task automatic finish_request();
    logic [DATA_W-1:0] exp_d;
    req_seen = 1'b0;
    if (expect_q.size() != 0) begin
      fault("master transfers missing before the slave ack");
      expect_q.delete();
    end
    if ((xfers == 0) !== exp_hit_i) value_error("hit", xfers == 0, exp_hit_i);
    if (exp_hit_i && lat != 3) value_error("s_ack_o latency", lat, 3);
    exp_d = shadow_word(s_adr_i);
    if (!s_we_i && s_dat_o !== exp_d) value_error("s_dat_o", s_dat_o, exp_d);
    if (s_we_i) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (s_sel_i[b]) exp_d[8*b +: 8] = s_dat_i[8*b +: 8];
      end
      shadow[s_adr_i] = exp_d;
      dirty_m[req.row][req.wsel] = 1'b1;
    end
  endtask

  // outputs change on the rising edge, so the falling edge sees them settled.
  always @(negedge clk_i) begin
    if (rst_i) begin
      valid_m = '0;
      req_seen = 1'b0;
      prev_pend = 1'b0;
      prev_ack = 1'b0;
      cycles = 0;
      if (s_ack_o !== 1'b0 || m_cyc_o !== 1'b0 || m_we_o !== 1'b0 || s_dat_o !== '0) begin
        fault("outputs active during reset");
      end
    end else begin
      cycles++;
      if (cycles <= ROWS && (s_ack_o || m_cyc_o || m_we_o)) begin
        fault("bus activity during the init sweep");
      end
      if (m_cyc_o && (m_stb_o !== 1'b1 || m_sel_o !== '1)) begin
        value_error("m_stb_o/m_sel_o", {m_stb_o, m_sel_o}, 5'h1f);
      end
      if (prev_ack && m_cyc_o) fault("no idle cycle after a master ack");
      bus_now = {m_we_o, m_adr_o, m_dat_o};
      if (prev_pend && m_cyc_o !== 1'b1) begin
        fault("master cycle dropped before its ack");
      end else if (prev_pend && bus_now !== prev_xfer) begin
        value_error("m_we_o/m_adr_o/m_dat_o held", bus_now, prev_xfer);
      end
      prev_xfer = bus_now;
      prev_pend = m_cyc_o && !m_ack_i;
      prev_ack = m_cyc_o && m_ack_i;
      if (m_cyc_o && m_ack_i) master_xfer();
      if (s_cyc_i && s_stb_i && !req_seen) begin
        start_request();
      end else if (req_seen) begin
        lat++;
      end
      if (s_ack_o) begin
        if (!req_seen) fault("slave ack without a request");
        else finish_request();
      end
    end
  end

endmodule

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         s_cyc_i,
  input  wire logic                         s_stb_i,
  input  wire logic                         s_we_i,
  input  wire logic [cache_pkg::ADDR_W-1:0] s_adr_i,
  input  wire logic [cache_pkg::SEL_W-1:0]  s_sel_i,
  input  wire logic [cache_pkg::DATA_W-1:0] s_dat_i,
  output logic      [cache_pkg::DATA_W-1:0] s_dat_o,
  output logic                              s_ack_o,
  output logic                              m_cyc_o,
  output logic                              m_we_o,
  output logic      [cache_pkg::ADDR_W-1:0] m_adr_o,
  output logic      [cache_pkg::DATA_W-1:0] m_dat_o,
  input  wire logic [cache_pkg::DATA_W-1:0] m_dat_i,
  input  wire logic                         m_ack_i,
  row_if.ctrl                               tag_bus,
  row_if.ctrl                               line_bus
);
  import cache_pkg::*;

  cache_state_t      state, state_next;
  logic [ROW_W-1:0]  init_cnt;
  logic [WSEL_W-1:0] wcnt, wcnt_next;
  line_t             line_buf;

  addr_t             req;
  tag_entry_t        tag_rd, tag_wr;
  line_t             line_rd, line_wr, merged_line;
  logic [ROW_W-1:0]  row_addr;
  logic              request;
  logic              hit;
  logic              last_word;
  logic              victim_dirty;
  logic              store_we;

  function automatic logic [DATA_W-1:0] merge_word(
    input logic [DATA_W-1:0] old_w,
    input logic [DATA_W-1:0] new_w,
    input logic [SEL_W-1:0]  sel
  );
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign req = addr_t'(s_adr_i); // held by the master until ack.
  assign tag_rd = tag_bus.rdata;
  assign line_rd = line_bus.rdata;

  assign request = s_cyc_i && s_stb_i;
  assign hit = tag_rd.valid && (tag_rd.tag == req.tag);
  assign last_word = (wcnt == WSEL_W'(WORDS_PER_ROW - 1));
  assign victim_dirty = tag_rd.valid && (|tag_rd.dirty);
  assign s_ack_o = (state == DONE);

  always_comb begin
    merged_line = line_rd;
    merged_line[req.wsel] = merge_word(line_rd[req.wsel], s_dat_i, s_sel_i);
  end

  always_comb begin
    state_next = state;
    wcnt_next = wcnt;
    m_cyc_o = 1'b0;
    m_we_o = 1'b0;
    m_adr_o = '0;
    m_dat_o = '0;
    case (state)
      INIT: begin
        if (init_cnt == ROW_W'(ROWS - 1)) begin
          state_next = IDLE;
        end
      end
      IDLE: begin
        if (request) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        state_next = hit ? HIT : MISS;
      end
      HIT: begin
        state_next = DONE;
      end
      DONE: begin
        state_next = IDLE;
      end
      MISS: begin
        wcnt_next = '0;
        state_next = victim_dirty ? WB_REQ : FILL_REQ;
      end
      WB_REQ: begin
        if (tag_rd.dirty[wcnt]) begin
          m_cyc_o = 1'b1;
          m_we_o = 1'b1;
          m_adr_o = {tag_rd.tag, req.row, wcnt}; // victim line address.
          m_dat_o = line_rd[wcnt];
          if (m_ack_i) begin
            state_next = WB_GAP;
          end
        end else if (last_word) begin
          state_next = WB_COMMIT;
        end else begin
          wcnt_next = wcnt + 1'b1; // clean word is skipped.
        end
      end
      WB_GAP: begin
        if (last_word) begin
          state_next = WB_COMMIT;
        end else begin
          wcnt_next = wcnt + 1'b1;
          state_next = WB_REQ;
        end
      end
      WB_COMMIT: begin
        wcnt_next = '0;
        state_next = FILL_REQ;
      end
      FILL_REQ: begin
        m_cyc_o = 1'b1;
        m_adr_o = {req.tag, req.row, wcnt};
        if (m_ack_i) begin
          state_next = FILL_GAP;
        end
      end
      FILL_GAP: begin
        if (last_word) begin
          state_next = FILL_COMMIT;
        end else begin
          wcnt_next = wcnt + 1'b1;
          state_next = FILL_REQ;
        end
      end
      FILL_COMMIT: begin
        state_next = LOOKUP; // the request now hits.
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_comb begin
    row_addr = (state == INIT) ? init_cnt : req.row;
    tag_wr = tag_rd;
    line_wr = line_buf;
    case (state)
      INIT: begin
        tag_wr = '0;
        line_wr = '0;
      end
      DONE: begin
        tag_wr.dirty[req.wsel] = 1'b1;
      end
      WB_COMMIT: begin
        tag_wr.dirty = '0;
        line_wr = line_rd;
      end
      FILL_COMMIT: begin
        tag_wr.valid = 1'b1;
        tag_wr.dirty = '0;
        tag_wr.tag = req.tag;
      end
      default: begin
        tag_wr = tag_rd;
      end
    endcase
  end

  assign store_we = (state == INIT) || (state == DONE && s_we_i) ||
                    (state == WB_COMMIT) || (state == FILL_COMMIT);

  assign tag_bus.addr = row_addr;
  assign tag_bus.we = store_we;
  assign tag_bus.wdata = tag_wr;
  assign line_bus.addr = row_addr;
  assign line_bus.we = store_we;
  assign line_bus.wdata = line_wr;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= INIT;
      wcnt <= '0;
      init_cnt <= '0;
    end else begin
      state <= state_next;
      wcnt <= wcnt_next;
      if (state == INIT) begin
        init_cnt <= init_cnt + 1'b1;
      end
    end
  end

  // line_buf holds the merged row of a write hit, or the line being filled.
  always_ff @(posedge clk_i) begin
    if (state == HIT && s_we_i) begin
      line_buf <= merged_line;
    end else if (state == FILL_REQ && m_ack_i) begin
      line_buf[wcnt] <= m_dat_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s_dat_o <= '0;
    end else if (state == HIT && !s_we_i) begin
      s_dat_o <= line_rd[req.wsel]; // valid during the ack in DONE.
    end
  end

endmodule

`default_nettype wire

/* cache_patterns.hex */
// one word per request: op digit (bit0 write, bit1 hit expected, f ends the list),
// then address (7 digits), byte selects (1 digit) and write data (8 digits).
00000441f00000000
20000441f00000000
20000443f00000000
30000441f12345678
300004425aabbccdd
20000442f00000000
20000441f00000000
30000442811000000
20000442f00000000
00000840f00000000
00000441f00000000
20000442f00000000
10000c8030000beef
20000c80f00000000
30000c83fdeadbeef
30000c80c12340000
10001083fcafef00d
00000c80f00000000
00001083f00000000
01fffffff00000000
31ffffff1000000a5
21fffffff00000000
00000000f00000000
100017fcf55aa55aa
01fffffff00000000
f0000000000000000

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  localparam int ADDR_W = 25;
  localparam int TAG_W = 15;
  localparam int ROW_W = 8;
  localparam int WSEL_W = 2;
  localparam int WORDS_PER_ROW = 4;
  localparam int ROWS = 256;
  localparam int DATA_W = 32;
  localparam int SEL_W = 4;

  // word address as seen on the slave port, msb first.
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ROW_W-1:0]  row;
    logic [WSEL_W-1:0] wsel;
  } addr_t;

  typedef struct packed {
    logic                     valid;
    logic [WORDS_PER_ROW-1:0] dirty; // one bit per word.
    logic [TAG_W-1:0]         tag;
  } tag_entry_t;

  typedef logic [WORDS_PER_ROW-1:0][DATA_W-1:0] line_t;

  typedef enum logic [3:0] {
    INIT        = 4'h0,
    IDLE        = 4'h1,
    LOOKUP      = 4'h2,
    HIT         = 4'h3,
    DONE        = 4'h4,
    MISS        = 4'h5,
    FILL_REQ    = 4'h6,
    FILL_GAP    = 4'h7,
    WB_REQ      = 4'h8,
    WB_GAP      = 4'h9,
    FILL_COMMIT = 4'ha,
    WB_COMMIT   = 4'hb
  } cache_state_t;

endpackage

`default_nettype wire

/* row_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface row_if #(
  parameter type T = logic
);
  import cache_pkg::*;

  logic [ROW_W-1:0] addr;
  logic             we;
  T                 wdata;
  T                 rdata; // row at the address of the previous cycle.

  modport ctrl (
    output addr,
    output we,
    output wdata,
    input  rdata
  );

  modport mem (
    input  addr,
    input  we,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* row_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module row_ram #(
  parameter type T = logic,
  parameter int DEPTH = cache_pkg::ROWS
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  row_if.mem        mem
);

  T store [DEPTH];

  always_ff @(posedge clk_i) begin
    if (mem.we) begin
      store[mem.addr] <= mem.wdata;
    end
  end

  // a write shows up on the read port in the same edge, so the controller
  // can re-check a freshly committed row on the next cycle.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      mem.rdata <= '0;
    end else if (mem.we) begin
      mem.rdata <= mem.wdata;
    end else begin
      mem.rdata <= store[mem.addr];
    end
  end

endmodule

`default_nettype wire

/* tb_wb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_cache;
  import cache_pkg::*;

  localparam logic [31:0] FILL_XOR = 32'h5a5ac3c3;
  localparam logic [31:0] LFSR_SEED = 32'h9f84;
  localparam int MAX_RECORDS = 64;
  localparam int ACK_TIMEOUT = 2000;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              s_cyc_i, s_stb_i, s_we_i;
  logic [ADDR_W-1:0] s_adr_i, m_adr_o;
  logic [SEL_W-1:0]  s_sel_i, m_sel_o;
  logic [DATA_W-1:0] s_dat_i, s_dat_o, m_dat_o;
  logic [DATA_W-1:0] m_dat_i = '0;
  logic              s_ack_o, m_cyc_o, m_stb_o, m_we_o;
  logic              m_ack_i = 1'b0;
  logic              exp_hit;
  logic [67:0]       patterns [MAX_RECORDS]; // op, address, selects, data.
  logic [DATA_W-1:0] mem_model [logic [ADDR_W-1:0]];
  logic [31:0]       lfsr = LFSR_SEED;
  logic              mem_armed;
  logic [1:0]        mem_delay;
  int                checker_errors;
  int                faults = 0;
  int                requests = 0;

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [1:0] draw_delay();
    logic [1:0] d;
    for (int i = 0; i < 2; i++) begin
      d[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return d;
  endfunction

  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    if (mem_model.exists(a)) begin
      return mem_model[a];
    end
    return DATA_W'(a) ^ FILL_XOR;
  endfunction

  // main memory model that acks each transfer after a random wait.
  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      m_ack_i <= 1'b0;
      m_dat_i <= '0;
      mem_armed <= 1'b0;
      mem_delay <= '0;
    end else if (m_ack_i) begin
      m_ack_i <= 1'b0;
    end else if (m_cyc_o && !mem_armed) begin
      mem_armed <= 1'b1;
      mem_delay <= draw_delay();
    end else if (mem_armed) begin
      if (mem_delay == 2'd0) begin
        mem_armed <= 1'b0;
        m_ack_i <= 1'b1;
        if (m_we_o) mem_model[m_adr_o] = m_dat_o;
        else m_dat_i <= mem_word(m_adr_o);
      end else begin
        mem_delay <= mem_delay - 1'b1;
      end
    end
  end

  wb_cache UUT (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_cyc_i(s_cyc_i), .s_stb_i(s_stb_i), .s_we_i(s_we_i), .s_adr_i(s_adr_i),
    .s_sel_i(s_sel_i), .s_dat_i(s_dat_i), .s_dat_o(s_dat_o), .s_ack_o(s_ack_o),
    .m_cyc_o(m_cyc_o), .m_stb_o(m_stb_o), .m_we_o(m_we_o), .m_adr_o(m_adr_o),
    .m_sel_o(m_sel_o), .m_dat_o(m_dat_o), .m_dat_i(m_dat_i), .m_ack_i(m_ack_i)
  );

  cache_checker #(.FILL_XOR(FILL_XOR)) u_checker (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_cyc_i(s_cyc_i), .s_stb_i(s_stb_i), .s_we_i(s_we_i), .s_adr_i(s_adr_i),
    .s_sel_i(s_sel_i), .s_dat_i(s_dat_i), .s_dat_o(s_dat_o), .s_ack_o(s_ack_o),
    .m_cyc_o(m_cyc_o), .m_stb_o(m_stb_o), .m_we_o(m_we_o), .m_adr_o(m_adr_o),
    .m_sel_o(m_sel_o), .m_dat_o(m_dat_o), .m_ack_i(m_ack_i),
    .exp_hit_i(exp_hit), .err_cnt_o(checker_errors)
  );

  task automatic wait_ack(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < ACK_TIMEOUT; n++) begin
      @(negedge clk_i);
      if (s_ack_o === 1'b1) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) $display("no slave ack within %0d cycles at %0t", ACK_TIMEOUT, $time);
  endtask

  task automatic run_patterns();
    logic [67:0] rec;
    bit          ok;
    for (int i = 0; i < MAX_RECORDS; i++) begin
      rec = patterns[i];
      if ((^rec) === 1'bx || rec[67:64] == 4'hf) break; // end marker.
      @(posedge clk_i);
      s_cyc_i <= 1'b1;
      s_stb_i <= 1'b1;
      s_we_i <= rec[64];
      exp_hit <= rec[65];
      s_adr_i <= rec[60:36];
      s_sel_i <= rec[35:32];
      s_dat_i <= rec[31:0];
      requests++;
      wait_ack(ok);
      @(posedge clk_i);
      s_cyc_i <= 1'b0;
      s_stb_i <= 1'b0;
      if (!ok) begin
        faults++;
        break;
      end
    end
  endtask

  initial begin
    rst_i = 1'b1;
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
    s_we_i = 1'b0;
    s_adr_i = '0;
    s_sel_i = '0;
    s_dat_i = '0;
    exp_hit = 1'b0;
    $readmemh("cache_patterns.hex", patterns);
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    run_patterns();
    if (requests == 0) begin
      $display("no request records were read from the pattern file");
      faults++;
    end
    repeat (3) @(posedge clk_i);
    $display("requests %0d, checker errors %0d, testbench faults %0d",
             requests, checker_errors, faults);
    if (checker_errors == 0 && faults == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* wb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_cache (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  input  wire logic                         s_cyc_i,
  input  wire logic                         s_stb_i,
  input  wire logic                         s_we_i,
  input  wire logic [cache_pkg::ADDR_W-1:0] s_adr_i,
  input  wire logic [cache_pkg::SEL_W-1:0]  s_sel_i,
  input  wire logic [cache_pkg::DATA_W-1:0] s_dat_i,
  output logic      [cache_pkg::DATA_W-1:0] s_dat_o,
  output logic                              s_ack_o,
  output logic                              m_cyc_o,
  output logic                              m_stb_o,
  output logic                              m_we_o,
  output logic      [cache_pkg::ADDR_W-1:0] m_adr_o,
  output logic      [cache_pkg::SEL_W-1:0]  m_sel_o,
  output logic      [cache_pkg::DATA_W-1:0] m_dat_o,
  input  wire logic [cache_pkg::DATA_W-1:0] m_dat_i,
  input  wire logic                         m_ack_i
);
  import cache_pkg::*;

  row_if #(.T(tag_entry_t)) tag_bus ();
  row_if #(.T(line_t))      line_bus ();

  cache_ctrl u_ctrl (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_cyc_i  (s_cyc_i),
    .s_stb_i  (s_stb_i),
    .s_we_i   (s_we_i),
    .s_adr_i  (s_adr_i),
    .s_sel_i  (s_sel_i),
    .s_dat_i  (s_dat_i),
    .s_dat_o  (s_dat_o),
    .s_ack_o  (s_ack_o),
    .m_cyc_o  (m_cyc_o),
    .m_we_o   (m_we_o),
    .m_adr_o  (m_adr_o),
    .m_dat_o  (m_dat_o),
    .m_dat_i  (m_dat_i),
    .m_ack_i  (m_ack_i),
    .tag_bus  (tag_bus),
    .line_bus (line_bus)
  );

  row_ram #(.T(tag_entry_t), .DEPTH(ROWS)) u_tag_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .mem   (tag_bus)
  );

  row_ram #(.T(line_t), .DEPTH(ROWS)) u_line_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .mem   (line_bus)
  );

  assign m_stb_o = m_cyc_o;
  assign m_sel_o = '1; // memory side always moves whole words.

endmodule

`default_nettype wire
